// ==== verilog/dmaPkg.sv ====
`default_nettype none

package dmaPkg;

  localparam int numChannels = 4;
  localparam int addrW = 32;
  localparam int countW = 14;
  localparam int scanW = 8;

  localparam logic [scanW-1:0] hblankLine = 8'd240;
  localparam logic [scanW-1:0] vblankLine = 8'd160;

  // bus size codes
  localparam logic [1:0] sizeHalf = 2'd1;
  localparam logic [1:0] sizeWord = 2'd2;

  // address control
  localparam logic [1:0] ctlInc = 2'd0;
  localparam logic [1:0] ctlDec = 2'd1;
  localparam logic [1:0] ctlFixed = 2'd2;
  localparam logic [1:0] ctlIncReload = 2'd3; // dst only, reload on repeat

  // start timing
  localparam logic [1:0] timeNow = 2'd0;
  localparam logic [1:0] timeVblank = 2'd1;
  localparam logic [1:0] timeHblank = 2'd2;
  localparam logic [1:0] timeSpecial = 2'd3; // never starts

  typedef struct packed {
    logic [addrW-1:0] srcAddr;
    logic [addrW-1:0] dstAddr;
    logic [countW-1:0] unitCount;
    logic enable;
    logic irqEn;
    logic [1:0] timing;
    logic repeatEn;
    logic wordSize; // 1 = 32-bit units
    logic [1:0] srcCtl;
    logic [1:0] dstCtl;
  } chanCfg_t;

  typedef struct packed {
    logic [addrW-1:0] addr;
    logic [addrW-1:0] wdata;
    logic [1:0] size;
    logic wen;
  } busReq_t;

  typedef struct packed {
    logic [addrW-1:0] addr;
    logic [addrW-1:0] data;
    logic wordSize;
    logic write;
    logic setWdata;
  } chanBus_t;

endpackage

`default_nettype wire

// ==== verilog/dmaTrigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTrigger import dmaPkg::*; (
  input  chanCfg_t         cfg,
  input  logic [scanW-1:0] hcount,
  input  logic [scanW-1:0] vcount,
  input  logic             cpuPreemptable,
  output logic             start
);

  logic timingHit;

  always_comb begin
    case (cfg.timing)
      timeNow: timingHit = 1'b1;
      timeHblank: timingHit = (hcount == hblankLine);
      timeVblank: timingHit = (vcount == vblankLine);
      default: timingHit = 1'b0; // special mode is not supported here
    endcase
  end

  // the cpu has to be at a point where it can give up the bus
  assign start = timingHit && cpuPreemptable;

endmodule

`default_nettype wire

// ==== verilog/dmaSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaSequencer import dmaPkg::*; (
  input  logic     clk,
  input  logic     rst_b,
  input  chanCfg_t cfg,
  input  logic     start,
  input  logic     memWait,
  input  logic     preempted,
  input  logic     allowedToBegin,
  input  logic     xferDone,
  output logic     load,
  output logic     stepSrc,
  output logic     stepDst,
  output logic     storeRData,
  output logic     active,
  output logic     write,
  output logic     setWdata,
  output logic     midUnit,
  output logic     irq,
  output logic     dmaDisable
);

  typedef enum logic [2:0] {OFF, IDLE, QUEUED, READ, WRITE, PREEMPTED} seqState_t;

  seqState_t cs, ns;
  logic enablePrev;
  logic enableRise;
  logic beginOk;

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      cs <= OFF;
      enablePrev <= 1'b0;
    end else begin
      cs <= ns;
      enablePrev <= cfg.enable;
    end
  end

  assign enableRise = cfg.enable && !enablePrev;
  assign beginOk = !preempted && !memWait && allowedToBegin;

  always_comb begin
    ns = cs;
    load = 1'b0;
    stepSrc = 1'b0;
    stepDst = 1'b0;
    storeRData = 1'b0;
    active = 1'b0;
    write = 1'b0;
    setWdata = 1'b0;
    midUnit = 1'b0;
    irq = 1'b0;
    dmaDisable = 1'b0;
    case (cs)
      OFF: begin
        if (enableRise) begin
          load = 1'b1;
          ns = IDLE;
        end
      end
      IDLE: begin
        if (!cfg.enable) begin
          ns = OFF;
        end else if (start) begin
          if (beginOk) begin
            ns = READ;
            active = 1'b1; // claim the bus in the decision cycle
          end else begin
            ns = QUEUED; // remember the start, hblank only lasts a cycle
          end
        end
      end
      QUEUED, PREEMPTED: begin
        if (!cfg.enable) begin
          ns = OFF;
        end else if (beginOk) begin
          ns = READ;
          active = 1'b1;
        end
      end
      READ: begin
        active = 1'b1;
        if (!memWait) begin
          if (!cfg.enable) begin
            ns = OFF;
          end else begin
            ns = WRITE;
            midUnit = 1'b1;
            stepSrc = 1'b1;
            storeRData = 1'b1;
          end
        end
      end
      WRITE: begin
        active = 1'b1;
        write = 1'b1;
        setWdata = 1'b1;
        if (!memWait) begin
          if (!cfg.enable) begin
            ns = OFF;
          end else if (xferDone) begin
            irq = cfg.irqEn;
            if (cfg.repeatEn) begin
              // restart the run: counter clears, dst steps or reloads
              ns = IDLE;
              load = 1'b1;
              stepDst = 1'b1;
            end else begin
              ns = OFF;
              dmaDisable = 1'b1;
            end
          end else begin
            stepDst = 1'b1;
            ns = preempted ? PREEMPTED : READ; // unit boundary
          end
        end
      end
      default: ns = OFF;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/dmaAddrGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaAddrGen import dmaPkg::*; (
  input  logic             clk,
  input  logic             rst_b,
  input  chanCfg_t         cfg,
  input  logic             load,
  input  logic             stepSrc,
  input  logic             stepDst,
  input  logic             storeRData,
  input  logic             write,
  input  logic [addrW-1:0] rdata,
  output logic             xferDone,
  output chanBus_t         chanBus
);

  logic [addrW-1:0] srcAddr, dstAddr;
  logic [addrW-1:0] srcNext, dstNext;
  logic [addrW-1:0] stepAmt;
  logic [addrW-1:0] dataLatch;
  logic [countW-1:0] unitsDone;
  logic fullLoad;

  function automatic logic [addrW-1:0] stepAddr(input logic [addrW-1:0] a,
                                                input logic [1:0] ctl,
                                                input logic [addrW-1:0] amt);
    case (ctl)
      ctlDec: stepAddr = a - amt;
      ctlFixed: stepAddr = a;
      default: stepAddr = a + amt; // inc and inc-reload
    endcase
  endfunction

  assign stepAmt = cfg.wordSize ? addrW'(4) : addrW'(2);
  assign srcNext = stepAddr(srcAddr, cfg.srcCtl, stepAmt);
  assign dstNext = stepAddr(dstAddr, cfg.dstCtl, stepAmt);

  // load together with stepDst is the restart of a repeat run
  assign fullLoad = load && !stepDst;

  always_ff @(posedge clk) begin
    if (fullLoad)
      srcAddr <= cfg.srcAddr;
    else if (stepSrc)
      srcAddr <= srcNext;

    if (fullLoad || (load && cfg.dstCtl == ctlIncReload))
      dstAddr <= cfg.dstAddr;
    else if (stepDst)
      dstAddr <= dstNext;

    if (storeRData)
      dataLatch <= rdata;
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b)
      unitsDone <= '0;
    else if (load)
      unitsDone <= '0;
    else if (stepSrc)
      unitsDone <= unitsDone + 1'b1;
  end

  assign xferDone = (unitsDone == cfg.unitCount);

  assign chanBus.addr = write ? dstAddr : srcAddr;
  assign chanBus.data = dataLatch;
  assign chanBus.wordSize = cfg.wordSize;
  assign chanBus.write = write;
  assign chanBus.setWdata = write; // channel overrides with the sequencer's flag

endmodule

`default_nettype wire

// ==== verilog/dmaChannel.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaChannel import dmaPkg::*; (
  input  logic             clk,
  input  logic             rst_b,
  input  chanCfg_t         cfg,
  input  logic [scanW-1:0] hcount,
  input  logic [scanW-1:0] vcount,
  input  logic             cpuPreemptable,
  input  logic             memWait,
  input  logic             preempted,
  input  logic             allowedToBegin,
  input  logic [addrW-1:0] rdata,
  output chanBus_t         chanBus,
  output logic             active,
  output logic             midUnit,
  output logic             irq,
  output logic             dmaDisable
);

  logic start;
  logic xferDone;
  logic load, stepSrc, stepDst, storeRData;
  logic write, setWdata;
  chanBus_t genBus;

  dmaTrigger u_trigger (
    .cfg, .hcount, .vcount, .cpuPreemptable, .start
  );

  dmaSequencer u_seq (
    .clk, .rst_b, .cfg, .start, .memWait, .preempted, .allowedToBegin, .xferDone,
    .load, .stepSrc, .stepDst, .storeRData, .active, .write, .setWdata,
    .midUnit, .irq, .dmaDisable
  );

  dmaAddrGen u_addr (
    .clk, .rst_b, .cfg, .load, .stepSrc, .stepDst, .storeRData, .write, .rdata,
    .xferDone, .chanBus(genBus)
  );

  always_comb begin
    chanBus = genBus;
    chanBus.setWdata = setWdata; // data lane only valid in the write state
  end

endmodule

`default_nettype wire

// ==== verilog/dmaBusMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaBusMux import dmaPkg::*; (
  input  chanBus_t               chanBus [numChannels],
  input  logic [numChannels-1:0] active,
  input  logic [numChannels-1:0] midUnit,
  output logic [numChannels-1:0] preempted,
  output logic                   allowedToBegin,
  output busReq_t                bus,
  output logic                   busActive
);

  chanBus_t sel;
  logic [addrW-1:0] laneData;

  // fixed priority, channel 0 highest
  always_comb begin
    preempted[0] = 1'b0;
    for (int i = 1; i < numChannels; i++) begin
      preempted[i] = preempted[i-1] | active[i-1];
    end
  end

  assign allowedToBegin = ~|midUnit;
  assign busActive = |active;

  always_comb begin
    sel = '0;
    for (int i = numChannels - 1; i >= 0; i--) begin
      if (active[i])
        sel = chanBus[i];
    end
    // a unit in its write cycle finishes before a new owner takes over
    for (int i = numChannels - 1; i >= 0; i--) begin
      if (active[i] && chanBus[i].write)
        sel = chanBus[i];
    end
  end

  always_comb begin
    laneData = sel.data;
    if (!sel.wordSize && sel.addr[1])
      laneData[31:16] = sel.data[15:0]; // upper halfword lane
  end

  always_comb begin
    bus = '0;
    if (busActive) begin
      bus.addr = sel.addr;
      bus.size = sel.wordSize ? sizeWord : sizeHalf;
      bus.wen = sel.write;
      bus.wdata = sel.setWdata ? laneData : '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dmaTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTop import dmaPkg::*; (
  input  logic                   clk,
  input  logic                   rst_b,
  input  chanCfg_t               cfg [numChannels],
  input  logic [scanW-1:0]       hcount,
  input  logic [scanW-1:0]       vcount,
  input  logic                   cpuPreemptable,
  input  logic                   memWait,
  input  logic [addrW-1:0]       rdata,
  output busReq_t                bus,
  output logic                   busActive,
  output logic [numChannels-1:0] dmaDisable,
  output logic [numChannels-1:0] irq
);

  chanBus_t chanBus [numChannels];
  logic [numChannels-1:0] active;
  logic [numChannels-1:0] midUnit;
  logic [numChannels-1:0] preempted;
  logic allowedToBegin;

  for (genvar i = 0; i < numChannels; i++) begin : g_chan
    dmaChannel u_chan (
      .clk, .rst_b,
      .cfg(cfg[i]),
      .hcount, .vcount, .cpuPreemptable, .memWait,
      .preempted(preempted[i]),
      .allowedToBegin,
      .rdata,
      .chanBus(chanBus[i]),
      .active(active[i]),
      .midUnit(midUnit[i]),
      .irq(irq[i]),
      .dmaDisable(dmaDisable[i])
    );
  end

  dmaBusMux u_mux (
    .chanBus, .active, .midUnit, .preempted, .allowedToBegin, .bus, .busActive
  );

endmodule

`default_nettype wire

// ==== tb/dmaTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTb import dmaPkg::*; ();

  localparam int fieldsPerTest = 11;

  logic clk, rst_b;
  chanCfg_t cfg [numChannels];
  logic [scanW-1:0] hcount, vcount;
  logic cpuPreemptable, memWait;
  logic [addrW-1:0] rdata;
  busReq_t bus;
  logic busActive;
  logic [numChannels-1:0] dmaDisable, irq;

  logic [31:0] tests [0:175];
  logic [31:0] seed;
  int wrCount [numChannels];
  int curKind, curChan, cycleLimit;
  logic armed, forcePre, prevHold;
  busReq_t prevBus;
  logic [numChannels-1:0] pendingClear;

  assign rdata = bus.addr ^ 32'h5a5a_0000; // memory model read data

  dmaTop u_dut (
    .clk, .rst_b, .cfg, .hcount, .vcount, .cpuPreemptable, .memWait, .rdata,
    .bus, .busActive, .dmaDisable, .irq
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [addrW-1:0] stepFrom(input logic [addrW-1:0] base,
                                                input logic [1:0] ctl,
                                                input logic [addrW-1:0] step,
                                                input int k);
    case (ctl)
      ctlDec: return base - step * addrW'(k);
      ctlFixed: return base;
      default: return base + step * addrW'(k);
    endcase
  endfunction

  // expected write k of a channel over all runs since enable
  function automatic busReq_t expectWrite(input int ch, input int k);
    busReq_t e;
    logic [addrW-1:0] step, src, d;
    step = cfg[ch].wordSize ? 32'd4 : 32'd2;
    src = stepFrom(cfg[ch].srcAddr, cfg[ch].srcCtl, step, k);
    if (cfg[ch].dstCtl == ctlIncReload)
      e.addr = cfg[ch].dstAddr + step * addrW'(k % int'(cfg[ch].unitCount));
    else
      e.addr = stepFrom(cfg[ch].dstAddr, cfg[ch].dstCtl, step, k);
    d = src ^ 32'h5a5a_0000;
    e.wdata = (!cfg[ch].wordSize && e.addr[1]) ? {d[15:0], d[15:0]} : d;
    e.size = cfg[ch].wordSize ? sizeWord : sizeHalf;
    e.wen = 1'b1;
    return e;
  endfunction

  task failRun(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task checkBus(input string name, input busReq_t got, input busReq_t exp);
    if (got !== exp)
      failRun({$sformatf("Mismatch %s: got addr %h wdata %h size %h wen %h", name,
                         got.addr, got.wdata, got.size, got.wen),
               $sformatf(", expected addr %h wdata %h size %h wen %h",
                         exp.addr, exp.wdata, exp.size, exp.wen)});
  endtask

  task checkPulse(input string name, input logic [numChannels-1:0] got,
                  input logic [numChannels-1:0] exp);
    if (got !== exp)
      failRun($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  task checkCycle();
    int ch;
    busReq_t exp;
    logic [numChannels-1:0] expIrq, expDis;
    expIrq = '0;
    expDis = '0;
    if (busActive && !armed)
      failRun("bus became active although the channel had no trigger");
    if (prevHold)
      checkBus("bus during memWait", bus, prevBus);
    if (bus.wen && !memWait) begin
      ch = curChan;
      if (curKind == 2 && bus.addr[24])
        ch = 0; // channel 0 runs in the offset region
      if (curKind == 2 && ch != 0 && wrCount[0] > 0 && wrCount[0] < int'(cfg[0].unitCount))
        failRun("lower priority channel wrote while channel 0 was running");
      exp = expectWrite(ch, wrCount[ch]);
      checkBus("bus write", bus, exp);
      wrCount[ch]++;
      if (wrCount[ch] % int'(cfg[ch].unitCount) == 0) begin
        expIrq[ch] = cfg[ch].irqEn;
        expDis[ch] = !cfg[ch].repeatEn;
      end
    end
    checkPulse("irq", irq, expIrq);
    checkPulse("dmaDisable", dmaDisable, expDis);
    prevHold = busActive && memWait;
    prevBus = bus;
  endtask

  // sample the settled cycle and drive the next one at the falling edge
  task stepCycle();
    #2;
    checkCycle();
    pendingClear = dmaDisable;
    @(negedge clk);
    for (int i = 0; i < numChannels; i++) begin
      if (pendingClear[i])
        cfg[i].enable = 1'b0; // software reacts to the disable request
    end
    seed = xorshift(seed);
    memWait = (seed[1:0] == 2'b00);
    cpuPreemptable = forcePre || (seed[4:2] != 3'b000);
    hcount = '0;
    vcount = '0;
  endtask

  task pulseTrigger(input logic [1:0] timing);
    armed = 1'b1;
    forcePre = 1'b1;
    stepCycle();
    if (timing == timeHblank)
      hcount = hblankLine;
    else
      vcount = vblankLine;
    stepCycle();
    forcePre = 1'b0;
  endtask

  task loadChan(input int ch, input int base, input logic [addrW-1:0] offset);
    cfg[ch].srcAddr = tests[base+2] + offset;
    cfg[ch].dstAddr = tests[base+3] + offset;
    cfg[ch].unitCount = countW'(tests[base+4]);
    cfg[ch].wordSize = tests[base+5][0];
    cfg[ch].srcCtl = tests[base+6][1:0];
    cfg[ch].dstCtl = tests[base+7][1:0];
    cfg[ch].timing = tests[base+8][1:0];
    cfg[ch].repeatEn = tests[base+9][0];
    cfg[ch].irqEn = tests[base+10][0];
    cfg[ch].enable = 1'b1;
  endtask

  task checkCount(input int ch, input int exp);
    if (wrCount[ch] != exp)
      failRun($sformatf("Mismatch write count ch%0d: got %h, expected %h",
                        ch, wrCount[ch], exp));
  endtask

  task runTest(input int base);
    int cnt;
    curKind = int'(tests[base]);
    curChan = int'(tests[base+1]);
    cnt = int'(tests[base+4]);
    for (int i = 0; i < numChannels; i++)
      wrCount[i] = 0;
    armed = (tests[base+8][1:0] == timeNow) && curKind != 1;
    loadChan(curChan, base, '0);
    case (curKind)
      1: begin
        repeat (50) stepCycle();
        cfg[curChan].enable = 1'b0;
      end
      2: begin
        while (wrCount[curChan] < 2) stepCycle();
        loadChan(0, base, 32'h0100_0000);
        while (cfg[0].enable || cfg[curChan].enable) stepCycle();
        checkCount(0, cnt);
        checkCount(curChan, cnt);
      end
      3: begin
        repeat (20) stepCycle();
        pulseTrigger(cfg[curChan].timing);
        while (wrCount[curChan] < cnt) stepCycle();
        armed = 1'b0; // repeat waits for the next trigger
        repeat (20) stepCycle();
        pulseTrigger(cfg[curChan].timing);
        while (wrCount[curChan] < 2 * cnt) stepCycle();
        cfg[curChan].enable = 1'b0;
      end
      default: begin
        if (!armed) begin
          repeat (20) stepCycle();
          pulseTrigger(cfg[curChan].timing);
        end
        while (cfg[curChan].enable) stepCycle();
        checkCount(curChan, cnt);
      end
    endcase
    armed = 1'b0;
    repeat (4) stepCycle();
  endtask

  initial begin
    wait (cycleLimit > 0);
    repeat (cycleLimit) @(posedge clk);
    failRun("timeout: the tests did not finish in time");
  end

  initial begin
    int idx, units;
    rst_b = 1'b0;
    hcount = '0;
    vcount = '0;
    cpuPreemptable = 1'b0;
    memWait = 1'b0;
    for (int i = 0; i < numChannels; i++) begin
      cfg[i] = '0;
      wrCount[i] = 0;
    end
    seed = 32'h2ce6;
    armed = 1'b0;
    forcePre = 1'b0;
    prevHold = 1'b0;
    prevBus = '0;
    pendingClear = '0;
    curKind = 0;
    curChan = 0;
    $readmemh("tb/dmaTests.txt", tests);
    idx = 0;
    units = 0;
    while (tests[idx] != 32'hff) begin
      units += int'(tests[idx+4]) * ((tests[idx] == 32'd2 || tests[idx] == 32'd3) ? 2 : 1);
      idx += fieldsPerTest;
    end
    cycleLimit = 200 * units;
    repeat (2) @(negedge clk);
    rst_b = 1'b1;
    idx = 0;
    while (tests[idx] != 32'hff) begin
      runTest(idx);
      idx += fieldsPerTest;
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/dmaPkg.sv
verilog/dmaTrigger.sv
verilog/dmaSequencer.sv
verilog/dmaAddrGen.sv
verilog/dmaChannel.sv
verilog/dmaBusMux.sv
verilog/dmaTop.sv
tb/dmaTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the DMA testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f verilog.f --top-module dmaTb -o dmaSim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/dmaSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
fi

if echo "$out" | grep -qx ">>> PASS"; then
  exit 0
else
  exit 1
fi

// ==== tb/dmaTests.txt ====
// kind chan src dst count wordSize srcCtl dstCtl timing repeat irqEn
// kind 0 single run, 1 never starts, 2 channel 0 preempts chan, 3 repeat run twice
0 1 00001000 00020000 08 1 0 0 0 0 1
0 3 00003000 00030002 06 0 1 2 0 0 1
0 2 00004000 00040000 05 0 0 0 0 0 1
0 0 00005000 00050000 04 1 0 0 2 0 1
0 1 00006000 00060000 04 0 0 1 1 0 0
1 2 00007000 00070000 04 1 0 0 3 0 1
2 2 00008000 00080000 0a 1 0 0 0 0 1
3 3 00009000 00090000 05 1 0 3 2 1 1
3 1 0000b000 000b0000 03 0 1 3 1 1 0
0 0 0000a000 000a0000 14 1 0 0 0 0 1
ff
